// ==== mhq_pkg.sv ====
package mhq_pkg;

    // Address and data geometry
    localparam int ADDR_WIDTH     = 32;
    localparam int WORD_SIZE      = 4;
    localparam int LINE_SIZE      = 16;
    localparam int OFFSET_WIDTH   = 4;
    localparam int WORDS_PER_LINE = LINE_SIZE / WORD_SIZE;

    // Full byte address
    typedef logic [ADDR_WIDTH-1:0] addr_t;

    // Line address with the offset bits stripped
    typedef logic [ADDR_WIDTH-OFFSET_WIDTH-1:0] line_addr_t;

    typedef logic [8*WORD_SIZE-1:0] word_t;

    typedef logic [WORD_SIZE-1:0] byte_sel_t;

    typedef logic [8*LINE_SIZE-1:0] line_t;

    // One bit per byte of a line
    typedef logic [LINE_SIZE-1:0] line_mask_t;

    // States of the line fetch master
    typedef enum logic [1:0] {
        FETCH_IDLE = 2'd0,
        FETCH_ADDR = 2'd1,
        FETCH_DATA = 2'd2,
        FETCH_DONE = 2'd3
    } fetch_state_t;

endpackage

// ==== mhq_alloc.sv ====
`timescale 1ns/100ps

module mhq_alloc #(
    parameter int MHQ_DEPTH = 4
) (
    input  logic                         clk,
    input  logic                         n_rst,
    input  logic                         i_enq_en,
    input  logic [MHQ_DEPTH-1:0]         i_match,
    input  logic                         i_fill,
    output logic [MHQ_DEPTH-1:0]         o_enq_sel,
    output logic [$clog2(MHQ_DEPTH)-1:0] o_enq_tag,
    output logic                         o_full
);

    localparam int TAG_WIDTH = $clog2(MHQ_DEPTH);

    // Pointers carry an extra wrap bit to tell full from empty
    logic [TAG_WIDTH:0]   tail;
    logic [TAG_WIDTH:0]   head;
    logic [TAG_WIDTH-1:0] tail_idx;
    logic                 merging;
    logic                 allocating;

    assign tail_idx   = tail[TAG_WIDTH-1:0];
    assign o_full     = (tail[TAG_WIDTH] != head[TAG_WIDTH]) &&
                        (tail_idx == head[TAG_WIDTH-1:0]);

    // A match always wins over a new allocation
    assign merging    = i_enq_en && (|i_match);
    assign allocating = i_enq_en && !(|i_match) && !o_full;

    always_comb begin
        o_enq_sel = '0;
        if (merging) begin
            o_enq_sel = i_match;
        end else if (allocating) begin
            o_enq_sel[tail_idx] = 1'b1;
        end
    end

    // One-hot select to binary tag
    always_comb begin
        o_enq_tag = '0;
        for (int i = 0; i < MHQ_DEPTH; i++) begin
            if (o_enq_sel[i]) begin
                o_enq_tag = TAG_WIDTH'(i);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!n_rst) begin
            tail <= '0;
        end else if (allocating) begin
            tail <= tail + 1'b1;
        end
    end

    // Local copy of the drain pointer that moves with every fill
    always_ff @(posedge clk) begin
        if (!n_rst) begin
            head <= '0;
        end else if (i_fill) begin
            head <= head + 1'b1;
        end
    end

    // Entries never hold the same line twice
    assert property (@(posedge clk) disable iff (!n_rst)
        i_enq_en |-> $onehot0(i_match));

    // A full queue takes no allocation and an empty one sees no fill
    assert property (@(posedge clk) disable iff (!n_rst)
        (TAG_WIDTH+1)'(tail - head) <= MHQ_DEPTH);

endmodule

// ==== mhq_entry.sv ====
`timescale 1ns/100ps

module mhq_entry (
    input  logic                             clk,
    input  logic                             n_rst,
    input  logic                             i_enq_sel,
    input  logic                             i_enq_we,
    input  mhq_pkg::line_addr_t              i_enq_line_addr,
    input  logic [mhq_pkg::OFFSET_WIDTH-1:0] i_enq_offset,
    input  mhq_pkg::word_t                   i_enq_data,
    input  mhq_pkg::byte_sel_t               i_enq_byte_sel,
    input  logic                             i_fill_sel,
    output logic                             o_match,
    output logic                             o_valid,
    output logic                             o_dirty,
    output mhq_pkg::line_addr_t              o_line_addr,
    output mhq_pkg::line_t                   o_data,
    output mhq_pkg::line_mask_t              o_byte_updated
);
    import mhq_pkg::*;

    line_mask_t enq_mask;

    // Store byte enables moved to their place in the line
    assign enq_mask = line_mask_t'(i_enq_byte_sel) << i_enq_offset;

    // An entry leaving this cycle cannot take a merge
    assign o_match = o_valid && (o_line_addr == i_enq_line_addr) && !i_fill_sel;

    always_ff @(posedge clk) begin
        if (!n_rst) begin
            o_valid        <= 1'b0;
            o_byte_updated <= '0;
        end else if (i_fill_sel) begin
            o_valid        <= 1'b0;
            o_byte_updated <= '0;
        end else if (i_enq_sel) begin
            o_valid <= 1'b1;
            if (i_enq_we) begin
                o_byte_updated <= o_byte_updated | enq_mask;
            end
        end
    end

    always_ff @(posedge clk) begin
        int byte_idx;
        if (i_enq_sel) begin
            o_line_addr <= i_enq_line_addr;
            // Load merges keep whatever dirty state the entry already has
            if (i_enq_we) begin
                o_dirty <= 1'b1;
            end else if (!o_valid) begin
                o_dirty <= 1'b0;
            end
        end
        if (i_enq_sel && i_enq_we) begin
            for (int k = 0; k < WORD_SIZE; k++) begin
                byte_idx = int'(i_enq_offset) + k;
                if (i_enq_byte_sel[k] && (byte_idx < LINE_SIZE)) begin
                    o_data[byte_idx*8 +: 8] <= i_enq_data[k*8 +: 8];
                end
            end
        end
    end

    // Allocator and fill unit must never pick the same slot together
    assert property (@(posedge clk) disable iff (!n_rst)
        !(i_enq_sel && i_fill_sel));

endmodule

// ==== mhq_fill.sv ====
`timescale 1ns/100ps

module mhq_fill #(
    parameter int MHQ_DEPTH = 4
) (
    input  logic                                clk,
    input  logic                                n_rst,
    input  logic [MHQ_DEPTH-1:0]                i_valid,
    input  logic [MHQ_DEPTH-1:0]                i_dirty,
    input  mhq_pkg::line_addr_t [MHQ_DEPTH-1:0] i_line_addr,
    input  mhq_pkg::line_t [MHQ_DEPTH-1:0]      i_data,
    input  mhq_pkg::line_mask_t [MHQ_DEPTH-1:0] i_byte_updated,
    input  logic                                i_fetch_done,
    input  mhq_pkg::line_t                      i_fetch_data,
    output logic [MHQ_DEPTH-1:0]                o_fill_sel,
    output logic                                o_fetch_req,
    output mhq_pkg::line_addr_t                 o_fetch_line_addr,
    output logic                                o_fill,
    output logic [$clog2(MHQ_DEPTH)-1:0]        o_fill_tag,
    output mhq_pkg::addr_t                      o_fill_addr,
    output logic                                o_fill_dirty,
    output mhq_pkg::line_t                      o_fill_data
);
    import mhq_pkg::*;

    localparam int TAG_WIDTH = $clog2(MHQ_DEPTH);

    logic [TAG_WIDTH-1:0] head;
    line_t                head_data;
    line_mask_t           head_mask;

    assign head_data = i_data[head];
    assign head_mask = i_byte_updated[head];

    // Fetch runs for the oldest entry only
    assign o_fetch_req       = i_valid[head];
    assign o_fetch_line_addr = i_line_addr[head];

    // The fill happens in the cycle the line arrives
    assign o_fill       = i_fetch_done;
    assign o_fill_sel   = i_fetch_done ? (MHQ_DEPTH'(1) << head) : '0;
    assign o_fill_tag   = head;
    assign o_fill_addr  = {i_line_addr[head], {OFFSET_WIDTH{1'b0}}};
    assign o_fill_dirty = i_dirty[head];

    // Stored bytes take priority over memory
    always_comb begin
        for (int i = 0; i < LINE_SIZE; i++) begin
            o_fill_data[i*8 +: 8] = head_mask[i] ? head_data[i*8 +: 8]
                                                 : i_fetch_data[i*8 +: 8];
        end
    end

    always_ff @(posedge clk) begin
        if (!n_rst) begin
            head <= '0;
        end else if (i_fetch_done) begin
            head <= head + 1'b1;
        end
    end

    // A completed fetch always belongs to a live head entry
    assert property (@(posedge clk) disable iff (!n_rst)
        i_fetch_done |-> i_valid[head]);

endmodule

// ==== mhq_line_fetch.sv ====
`timescale 1ns/100ps

module mhq_line_fetch (
    input  logic                clk,
    input  logic                n_rst,
    input  logic                i_fetch_req,
    input  mhq_pkg::line_addr_t i_fetch_line_addr,
    input  logic                i_arready,
    input  logic                i_rvalid,
    input  mhq_pkg::word_t      i_rdata,
    input  logic [1:0]          i_rresp,
    output logic                o_fetch_done,
    output mhq_pkg::line_t      o_fetch_data,
    output mhq_pkg::addr_t      o_araddr,
    output logic                o_arvalid,
    output logic                o_rready
);
    import mhq_pkg::*;

    localparam int WORD_IDX_WIDTH = $clog2(WORDS_PER_LINE);
    localparam int BYTE_OFF_WIDTH = $clog2(WORD_SIZE);

    fetch_state_t              state;
    fetch_state_t              next_state;
    line_addr_t                line_addr_q;
    logic [WORD_IDX_WIDTH-1:0] word_idx;
    logic                      last_word;

    assign last_word = (word_idx == WORD_IDX_WIDTH'(WORDS_PER_LINE - 1));

    // One outstanding read, address and data phases alternate
    always_comb begin
        next_state = state;
        case (state)
            FETCH_IDLE: begin
                if (i_fetch_req) begin
                    next_state = FETCH_ADDR;
                end
            end
            FETCH_ADDR: begin
                if (i_arready) begin
                    next_state = FETCH_DATA;
                end
            end
            FETCH_DATA: begin
                if (i_rvalid) begin
                    next_state = last_word ? FETCH_DONE : FETCH_ADDR;
                end
            end
            FETCH_DONE: begin
                next_state = FETCH_IDLE;
            end
            default: begin
                next_state = FETCH_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!n_rst) begin
            state    <= FETCH_IDLE;
            word_idx <= '0;
        end else begin
            state <= next_state;
            if (state == FETCH_IDLE) begin
                word_idx <= '0;
            end else if (state == FETCH_DATA && i_rvalid) begin
                word_idx <= word_idx + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state == FETCH_IDLE && i_fetch_req) begin
            line_addr_q <= i_fetch_line_addr;
        end
        if (state == FETCH_DATA && i_rvalid) begin
            o_fetch_data[word_idx*8*WORD_SIZE +: 8*WORD_SIZE] <= i_rdata;
        end
    end

    assign o_araddr     = {line_addr_q, word_idx, {BYTE_OFF_WIDTH{1'b0}}};
    assign o_arvalid    = (state == FETCH_ADDR);
    assign o_rready     = (state == FETCH_DATA);
    assign o_fetch_done = (state == FETCH_DONE);

    // Address must hold until the slave takes it
    assert property (@(posedge clk) disable iff (!n_rst)
        o_arvalid && !i_arready |=> o_arvalid && $stable(o_araddr));

    // The response code is not acted on, but it must be driven on every beat
    assert property (@(posedge clk) disable iff (!n_rst)
        o_rready && i_rvalid |-> !$isunknown(i_rresp));

endmodule

// ==== mhq_top.sv ====
`timescale 1ns/100ps

module mhq_top #(
    parameter int MHQ_DEPTH = 4
) (
    input  logic                         clk,
    input  logic                         n_rst,
    input  logic                         i_enq_en,
    input  logic                         i_enq_we,
    input  mhq_pkg::addr_t               i_enq_addr,
    input  mhq_pkg::word_t               i_enq_data,
    input  mhq_pkg::byte_sel_t           i_enq_byte_sel,
    output logic [$clog2(MHQ_DEPTH)-1:0] o_enq_tag,
    output logic                         o_full,
    output mhq_pkg::addr_t               o_araddr,
    output logic                         o_arvalid,
    input  logic                         i_arready,
    input  logic                         i_rvalid,
    input  mhq_pkg::word_t               i_rdata,
    input  logic [1:0]                   i_rresp,
    output logic                         o_rready,
    output logic                         o_fill,
    output logic [$clog2(MHQ_DEPTH)-1:0] o_fill_tag,
    output mhq_pkg::addr_t               o_fill_addr,
    output logic                         o_fill_dirty,
    output mhq_pkg::line_t               o_fill_data
);
    import mhq_pkg::*;

    logic [MHQ_DEPTH-1:0]       enq_sel;
    logic [MHQ_DEPTH-1:0]       match;
    logic [MHQ_DEPTH-1:0]       fill_sel;
    logic [MHQ_DEPTH-1:0]       ent_valid;
    logic [MHQ_DEPTH-1:0]       ent_dirty;
    line_addr_t [MHQ_DEPTH-1:0] ent_line_addr;
    line_t [MHQ_DEPTH-1:0]      ent_data;
    line_mask_t [MHQ_DEPTH-1:0] ent_byte_updated;
    logic                       fetch_req;
    line_addr_t                 fetch_line_addr;
    logic                       fetch_done;
    line_t                      fetch_data;

    mhq_alloc #(
        .MHQ_DEPTH (MHQ_DEPTH)
    ) u_alloc (
        .clk       (clk),
        .n_rst     (n_rst),
        .i_enq_en  (i_enq_en),
        .i_match   (match),
        .i_fill    (fetch_done),
        .o_enq_sel (enq_sel),
        .o_enq_tag (o_enq_tag),
        .o_full    (o_full)
    );

    // Enqueue fields go to every entry, the select picks the one that updates
    for (genvar i = 0; i < MHQ_DEPTH; i++) begin : g_entry
        mhq_entry u_entry (
            .clk             (clk),
            .n_rst           (n_rst),
            .i_enq_sel       (enq_sel[i]),
            .i_enq_we        (i_enq_we),
            .i_enq_line_addr (i_enq_addr[ADDR_WIDTH-1:OFFSET_WIDTH]),
            .i_enq_offset    (i_enq_addr[OFFSET_WIDTH-1:0]),
            .i_enq_data      (i_enq_data),
            .i_enq_byte_sel  (i_enq_byte_sel),
            .i_fill_sel      (fill_sel[i]),
            .o_match         (match[i]),
            .o_valid         (ent_valid[i]),
            .o_dirty         (ent_dirty[i]),
            .o_line_addr     (ent_line_addr[i]),
            .o_data          (ent_data[i]),
            .o_byte_updated  (ent_byte_updated[i])
        );
    end

    mhq_fill #(
        .MHQ_DEPTH (MHQ_DEPTH)
    ) u_fill (
        .clk               (clk),
        .n_rst             (n_rst),
        .i_valid           (ent_valid),
        .i_dirty           (ent_dirty),
        .i_line_addr       (ent_line_addr),
        .i_data            (ent_data),
        .i_byte_updated    (ent_byte_updated),
        .i_fetch_done      (fetch_done),
        .i_fetch_data      (fetch_data),
        .o_fill_sel        (fill_sel),
        .o_fetch_req       (fetch_req),
        .o_fetch_line_addr (fetch_line_addr),
        .o_fill            (o_fill),
        .o_fill_tag        (o_fill_tag),
        .o_fill_addr       (o_fill_addr),
        .o_fill_dirty      (o_fill_dirty),
        .o_fill_data       (o_fill_data)
    );

    mhq_line_fetch u_line_fetch (
        .clk               (clk),
        .n_rst             (n_rst),
        .i_fetch_req       (fetch_req),
        .i_fetch_line_addr (fetch_line_addr),
        .i_arready         (i_arready),
        .i_rvalid          (i_rvalid),
        .i_rdata           (i_rdata),
        .i_rresp           (i_rresp),
        .o_fetch_done      (fetch_done),
        .o_fetch_data      (fetch_data),
        .o_araddr          (o_araddr),
        .o_arvalid         (o_arvalid),
        .o_rready          (o_rready)
    );

endmodule

// ==== tb_mhq.sv ====
`timescale 1ns/100ps

module tb_mhq;

    localparam int          DEPTH       = 4;
    localparam int          TAG_W       = $clog2(DEPTH);
    localparam int          NUM_TESTS   = 5;
    localparam int          TIMEOUT_NS  = NUM_TESTS * 2000;
    localparam int          NUM_RANDOM  = 20;
    localparam logic [31:0] MEM_PATTERN = 32'h5a5a_0000;
    localparam logic [31:0] LFSR_SEED   = 32'h21f1_fe1d;
    localparam logic [31:0] LFSR_TAPS   = 32'h8020_0003;

    logic             clk;
    logic             n_rst;
    logic             enq_en;
    logic             enq_we;
    logic [31:0]      enq_addr;
    logic [31:0]      enq_data;
    logic [3:0]       enq_byte_sel;
    logic [TAG_W-1:0] enq_tag;
    logic             full;
    logic [31:0]      araddr;
    logic             arvalid;
    logic             arready;
    logic             rvalid;
    logic [31:0]      rdata;
    logic [1:0]       rresp;
    logic             rready;
    logic             fill;
    logic [TAG_W-1:0] fill_tag;
    logic [31:0]      fill_addr;
    logic             fill_dirty;
    logic [127:0]     fill_data;

    // Reference queue with one slot per allocation and pending slots from sb_head on
    logic [27:0]      sb_line[$];
    logic [127:0]     sb_data[$];
    logic [15:0]      sb_mask[$];
    logic             sb_dirty[$];
    logic [TAG_W-1:0] sb_tag[$];
    int               sb_head = 0;
    int               alloc_count = 0;
    int               mem_extra = 0;
    logic [31:0]      mem_lfsr = LFSR_SEED;
    logic [31:0]      req_lfsr = LFSR_SEED;
    logic [31:0]      rd_addr;

    mhq_top #(
        .MHQ_DEPTH (DEPTH)
    ) UUT (
        .clk            (clk),
        .n_rst          (n_rst),
        .i_enq_en       (enq_en),
        .i_enq_we       (enq_we),
        .i_enq_addr     (enq_addr),
        .i_enq_data     (enq_data),
        .i_enq_byte_sel (enq_byte_sel),
        .o_enq_tag      (enq_tag),
        .o_full         (full),
        .o_araddr       (araddr),
        .o_arvalid      (arvalid),
        .i_arready      (arready),
        .i_rvalid       (rvalid),
        .i_rdata        (rdata),
        .i_rresp        (rresp),
        .o_rready       (rready),
        .o_fill         (fill),
        .o_fill_tag     (fill_tag),
        .o_fill_addr    (fill_addr),
        .o_fill_dirty   (fill_dirty),
        .o_fill_data    (fill_data)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ LFSR_TAPS) : (s >> 1);
    endfunction

    // One LFSR step per bit taken
    task automatic draw_bits(input int n, inout logic [31:0] state, output logic [31:0] bits);
        bits = '0;
        for (int i = 0; i < n; i++) begin
            state = lfsr_next(state);
            bits  = {bits[30:0], state[0]};
        end
    endtask

    // Memory words with the stored bytes laid over them
    function automatic logic [127:0] expected_line(input logic [27:0] line,
                                                   input logic [127:0] data,
                                                   input logic [15:0] mask);
        logic [127:0] mem_line;
        logic [127:0] result;
        logic [31:0]  word_addr;
        for (int w = 0; w < 4; w++) begin
            word_addr            = {line, 4'h0} + 32'(4 * w);
            mem_line[w*32 +: 32] = word_addr ^ MEM_PATTERN;
        end
        for (int b = 0; b < 16; b++) begin
            result[b*8 +: 8] = mask[b] ? data[b*8 +: 8] : mem_line[b*8 +: 8];
        end
        return result;
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Checks failed");
        $fatal(1, "Run stopped at the first error");
    endtask

    task automatic check(input string name, input logic [127:0] actual,
                         input logic [127:0] expected);
        string msg;
        if (actual !== expected) begin
            msg = $sformatf("FAIL at %0t ns: %s is %0h, expected %0h",
                            $time, name, actual, expected);
            abort_run(msg);
        end
    endtask

    // Inputs change 1 ns after the rising edge
    task automatic wait_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic wait_drain();
        while (sb_head != sb_tag.size()) begin
            wait_cycle();
        end
    endtask

    // Holds the request until the queue takes it and tracks the reference queue
    task automatic enqueue(input logic we, input logic [31:0] addr, input logic [31:0] data,
                           input logic [3:0] be);
        int               hit;
        int               idx;
        logic             accepted;
        logic [127:0]     line_v;
        logic [15:0]      mask_v;
        logic [TAG_W-1:0] tag;
        enq_en       = 1'b1;
        enq_we       = we;
        enq_addr     = addr;
        enq_data     = data;
        enq_byte_sel = be;
        accepted     = 1'b0;
        tag          = '0;
        while (!accepted) begin
            hit = -1;
            // The slot filled this cycle is gone before the merge lands
            for (int i = sb_head + ((fill === 1'b1) ? 1 : 0); i < sb_tag.size(); i++) begin
                if (sb_line[i] == addr[31:4]) begin
                    hit = i;
                end
            end
            if (hit < 0 && full !== 1'b1) begin
                sb_line.push_back(addr[31:4]);
                sb_data.push_back('0);
                sb_mask.push_back('0);
                sb_dirty.push_back(1'b0);
                sb_tag.push_back(TAG_W'(alloc_count % DEPTH));
                alloc_count = alloc_count + 1;
                hit         = sb_tag.size() - 1;
            end
            if (hit >= 0) begin
                line_v = sb_data[hit];
                mask_v = sb_mask[hit];
                if (we) begin
                    for (int k = 0; k < 4; k++) begin
                        idx = int'(addr[3:0]) + k;
                        if (be[k] && idx < 16) begin
                            line_v[idx*8 +: 8] = data[k*8 +: 8];
                            mask_v[idx]        = 1'b1;
                        end
                    end
                    sb_dirty[hit] = 1'b1;
                end
                sb_data[hit] = line_v;
                sb_mask[hit] = mask_v;
                tag          = sb_tag[hit];
                @(negedge clk);
                check("o_enq_tag", 128'(enq_tag), 128'(tag));
                accepted = 1'b1;
            end
            wait_cycle();
        end
        enq_en = 1'b0;
    endtask

    // AXI4-Lite read slave serving one beat at a time with LFSR delays
    initial begin : axi_read_slave
        logic [31:0] delay_bits;
        arready = 1'b0;
        rvalid  = 1'b0;
        rdata   = '0;
        rresp   = 2'b00;
        forever begin
            if (arvalid === 1'b1) begin
                draw_bits(2, mem_lfsr, delay_bits);
                repeat (int'(delay_bits) + mem_extra) wait_cycle();
                arready = 1'b1;
                rd_addr = araddr;
                wait_cycle();
                arready = 1'b0;
                draw_bits(2, mem_lfsr, delay_bits);
                repeat (int'(delay_bits) + mem_extra) wait_cycle();
                rvalid = 1'b1;
                rdata  = rd_addr ^ MEM_PATTERN;
                rresp  = 2'b00;
                wait_cycle();
                rvalid = 1'b0;
            end else begin
                wait_cycle();
            end
        end
    end

    // Every fill is checked against the oldest pending slot
    always @(negedge clk) begin
        if (n_rst === 1'b1 && fill === 1'b1) begin
            if (sb_head >= sb_tag.size()) begin
                abort_run("A fill came out while no request was pending");
            end else begin
                check("o_fill_tag", 128'(fill_tag), 128'(sb_tag[sb_head]));
                check("o_fill_addr", 128'(fill_addr), 128'({sb_line[sb_head], 4'h0}));
                check("o_fill_dirty", 128'(fill_dirty), 128'(sb_dirty[sb_head]));
                check("o_fill_data", fill_data,
                      expected_line(sb_line[sb_head], sb_data[sb_head], sb_mask[sb_head]));
                sb_head = sb_head + 1;
            end
        end
    end

    initial begin
        #(TIMEOUT_NS);
        abort_run($sformatf("Timeout, tests still running after %0d ns", TIMEOUT_NS));
    end

    task automatic reset_then_load();
        check("o_fill", 128'(fill), '0);
        check("o_arvalid", 128'(arvalid), '0);
        check("o_rready", 128'(rready), '0);
        check("o_full", 128'(full), '0);
        enqueue(1'b0, 32'h0000_1040, 32'h0, 4'h0);
        wait_drain();
    endtask

    task automatic store_then_fill();
        enqueue(1'b1, 32'h0000_2008, 32'hcafe_f00d, 4'b1011);
        wait_drain();
    endtask

    // Load followed by two overlapping stores to the same line
    task automatic merge_same_line();
        enqueue(1'b0, 32'h0000_3000, 32'h0, 4'h0);
        enqueue(1'b1, 32'h0000_3004, 32'h1122_3344, 4'hf);
        enqueue(1'b1, 32'h0000_3006, 32'h0000_a5c3, 4'b0011);
        wait_drain();
    endtask

    task automatic fill_queue_in_order();
        mem_extra = 6;
        for (int n = 0; n < DEPTH; n++) begin
            enqueue(1'b0, 32'h0000_4000 + 32'(n * 16), 32'h0, 4'h0);
        end
        check("o_full", 128'(full), 128'(1'b1));
        while (fill !== 1'b1) begin
            check("o_full", 128'(full), 128'(1'b1));
            wait_cycle();
        end
        wait_cycle();
        check("o_full", 128'(full), '0);
        wait_drain();
        mem_extra = 0;
    endtask

    task automatic random_backpressure();
        logic [31:0] addr_v[NUM_RANDOM];
        logic [31:0] data_v[NUM_RANDOM];
        logic        we_v[NUM_RANDOM];
        logic [3:0]  be_v[NUM_RANDOM];
        logic [31:0] r;
        // Eight lines so that some requests merge
        for (int n = 0; n < NUM_RANDOM; n++) begin
            draw_bits(3, req_lfsr, r);
            addr_v[n] = 32'h0000_5000 + (r << 4);
            draw_bits(2, req_lfsr, r);
            addr_v[n] = addr_v[n] + (r << 2);
            draw_bits(1, req_lfsr, r);
            we_v[n] = r[0];
            draw_bits(32, req_lfsr, r);
            data_v[n] = r;
            draw_bits(4, req_lfsr, r);
            be_v[n] = r[3:0];
        end
        for (int n = 0; n < NUM_RANDOM; n++) begin
            enqueue(we_v[n], addr_v[n], data_v[n], be_v[n]);
        end
        wait_drain();
    endtask

    initial begin
        n_rst        = 1'b0;
        enq_en       = 1'b0;
        enq_we       = 1'b0;
        enq_addr     = '0;
        enq_data     = '0;
        enq_byte_sel = '0;
        repeat (10) @(posedge clk);
        #1;
        n_rst = 1'b1;
        reset_then_load();
        store_then_fill();
        merge_same_line();
        fill_queue_in_order();
        random_backpressure();
        $display("All checks passed");
        $finish;
    end

endmodule

// ==== project.f ====
mhq_pkg.sv
mhq_alloc.sv
mhq_entry.sv
mhq_fill.sv
mhq_line_fetch.sv
mhq_top.sv
tb_mhq.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the MHQ testbench, then search the log for the fail message
verilator --binary --timing --assert --top-module tb_mhq -f project.f > build.log 2>&1 \
    || { echo "Build failed, see build.log"; exit 1; }
./obj_dir/Vtb_mhq > sim.log 2>&1
grep -q "Checks failed" sim.log && { echo "Simulation failed, see sim.log"; exit 1; }
grep -q "All checks passed" sim.log && echo "Simulation passed" \
    || { echo "Simulation ended without a result, see sim.log"; exit 1; }
